/* rtl/cache_consts.svh */
// Cache geometry, memory credit count and datapath widths
`ifndef CACHE_CONSTS_SVH
`define CACHE_CONSTS_SVH

// Geometry of each L1, one 32-bit word per line
`define CACHE_LINES    8
`define CACHE_INDEX_W  3            // log2 of CACHE_LINES
`define CACHE_TAG_W    27           // ADDR_W minus index and byte offset

// External memory link
`define MEM_CREDITS    2            // Input queue slots, also tag FIFO depth
`define MEM_CREDIT_W   2            // Holds 0..MEM_CREDITS
`define MEM_TAG_PTR_W  1            // log2 of MEM_CREDITS

// Datapath
`define WORD_W         32
`define ADDR_W         32

`endif

/* rtl/cache_pkg.sv */
// Package cache_pkg with the shared word, address and requester types
`default_nettype none

`include "cache_consts.svh"

package cache_pkg;

  // Data word as seen on both the processor and memory sides
  typedef logic [`WORD_W-1:0] word_t;

  // Byte address, word aligned
  // Low two bits never reach memory decode
  typedef logic [`ADDR_W-1:0] addr_t;

  // Which L1 a front-side request came from
  typedef enum logic {
    REQ_ICACHE = 1'b0,
    REQ_DCACHE = 1'b1    // Also the arbitration winner on ties
  } req_src_t;

endpackage

`default_nettype wire

/* rtl/l1_cache.sv */
// Module l1_cache, direct-mapped single-word-line cache for instructions or data
`default_nettype none

`include "cache_consts.svh"

module l1_cache
  import cache_pkg::*;
#(
  parameter int WRITABLE = 0                           // 1 gives a write-through data cache
) (
  input  wire logic                      CLK,
  input  wire logic                      reset,
  // Line walk from the flush sequencer
  input  wire logic                      flush_step,
  input  wire logic [`CACHE_INDEX_W-1:0] flush_index,
  // Processor side
  input  wire logic                      ren,
  input  wire logic                      wen,
  input  wire addr_t                     addr,
  input  wire word_t                     wdata,
  output word_t                          rdata,
  output logic                           busy,
  output logic                           hit,
  output logic                           miss,
  // Memory side, toward the arbiter
  output logic                           mreq,
  output logic                           mwrite,
  output addr_t                          maddr,
  output word_t                          mwdata,
  input  wire logic                      mgrant,
  input  wire logic                      mresp_valid,
  input  wire word_t                     mresp_data
);

  typedef enum logic [1:0] {
    IDLE,       // Lookup happens here
    REQUEST,    // mreq held until grant
    WAIT_RESP   // One access outstanding
  } state_t;

  state_t state, state_next;

  // Line storage
  logic [`CACHE_LINES-1:0]   valid;
  logic [`CACHE_TAG_W-1:0]   tag_arr  [`CACHE_LINES];
  word_t                     data_arr [`CACHE_LINES];

  // Access captured when it leaves for memory
  addr_t addr_q;
  word_t wdata_q;
  logic  wr_q;

  logic                      wr_req;
  logic [`CACHE_INDEX_W-1:0] idx;
  logic [`CACHE_INDEX_W-1:0] idx_q;
  logic [`CACHE_TAG_W-1:0]   tag;
  logic [`CACHE_TAG_W-1:0]   tag_q;
  logic                      lookup_hit;
  logic                      latch;        // Capture the access
  logic                      fill;         // Read data arriving for the line
  logic                      line_write;   // Store hitting a valid line

  assign wr_req = (WRITABLE != 0) && wen;              // Read-only side drops stores
  assign idx    = addr[`CACHE_INDEX_W+1:2];            // Word address picks the line
  assign tag    = addr[`ADDR_W-1:`CACHE_INDEX_W+2];
  assign idx_q  = addr_q[`CACHE_INDEX_W+1:2];
  assign tag_q  = addr_q[`ADDR_W-1:`CACHE_INDEX_W+2];

  assign lookup_hit = valid[idx] && (tag_arr[idx] == tag);

  // Memory request fields come straight from the captured access
  assign mwrite = wr_q;
  assign maddr  = addr_q;
  assign mwdata = wdata_q;

  // Fill data bypasses the array in the completing cycle
  assign rdata = (state == WAIT_RESP) ? mresp_data : data_arr[idx];

  always_comb begin
    state_next = state;
    busy       = 1'b0;
    hit        = 1'b0;
    miss       = 1'b0;
    mreq       = 1'b0;
    latch      = 1'b0;
    fill       = 1'b0;
    line_write = 1'b0;
    case (state)
      IDLE: begin
        if (flush_step) begin
          busy = 1'b1;                                 // Stall everything while lines clear
        end else if (wr_req) begin
          busy       = 1'b1;                           // Every store goes to memory
          latch      = 1'b1;
          state_next = REQUEST;
        end else if (ren) begin
          if (lookup_hit) begin
            hit = 1'b1;                                // Done this cycle
          end else begin
            miss       = 1'b1;
            busy       = 1'b1;
            latch      = 1'b1;
            state_next = REQUEST;
          end
        end
      end
      REQUEST: begin
        busy = 1'b1;
        mreq = 1'b1;
        if (mgrant) state_next = WAIT_RESP;
      end
      WAIT_RESP: begin
        busy = 1'b1;
        if (mresp_valid) begin
          busy       = 1'b0;                           // Completes with the response
          state_next = IDLE;
          if (!wr_q) begin
            fill = 1'b1;
          end else if (valid[idx_q] && (tag_arr[idx_q] == tag_q)) begin
            line_write = 1'b1;                         // No allocate on a store miss
          end
        end
      end
      default: state_next = IDLE;
    endcase
  end

  // Control state and valid bits
  always_ff @(posedge CLK) begin
    if (reset) begin
      state <= IDLE;
      valid <= '0;
    end else begin
      state <= state_next;
      // A fill racing a flush must not leave the line valid
      if (fill && !flush_step) valid[idx_q] <= 1'b1;
      if (flush_step)          valid[flush_index] <= 1'b0;
    end
  end

  // Payload and line arrays
  always_ff @(posedge CLK) begin
    if (latch) begin
      addr_q  <= addr;
      wdata_q <= wdata;
      wr_q    <= wr_req;
    end
    if (fill) begin
      tag_arr[idx_q]  <= tag_q;
      data_arr[idx_q] <= mresp_data;
    end else if (line_write) begin
      data_arr[idx_q] <= wdata_q;                      // Keep the line in step with memory
    end
  end

endmodule

`default_nettype wire

/* rtl/front_side_arbiter.sv */
// Module front_side_arbiter, fixed-priority merge of two caches with response routing
`default_nettype none

module front_side_arbiter
  import cache_pkg::*;
(
  input  wire logic     CLK,
  input  wire logic     reset,
  // Instruction cache, reads only
  input  wire logic     i_mreq,
  input  wire addr_t    i_maddr,
  output logic          i_mgrant,
  output logic          i_mresp_valid,
  // Data cache
  input  wire logic     d_mreq,
  input  wire logic     d_mwrite,
  input  wire addr_t    d_maddr,
  input  wire word_t    d_mwdata,
  output logic          d_mgrant,
  output logic          d_mresp_valid,
  // Response data shared by both caches
  output word_t         mresp_data,
  // Merged request stream
  output logic          fs_valid,
  output logic          fs_write,
  output addr_t         fs_addr,
  output word_t         fs_wdata,
  output req_src_t      fs_src,
  input  wire logic     fs_ready,
  input  wire logic     fs_resp_valid,
  input  wire word_t    fs_resp_data,
  input  wire req_src_t fs_resp_src
);

  logic i_pend;   // Instruction access outstanding
  logic d_pend;   // Data access outstanding
  logic i_sel;
  logic d_sel;

  // Data side first, and never a second grant to a busy requester
  assign d_sel = d_mreq && !d_pend;
  assign i_sel = i_mreq && !i_pend && !d_sel;

  assign fs_valid = d_sel || i_sel;
  assign fs_write = d_sel && d_mwrite;                 // Instruction side only reads
  assign fs_addr  = d_sel ? d_maddr : i_maddr;
  assign fs_wdata = d_mwdata;                          // Only stores carry data
  assign fs_src   = d_sel ? REQ_DCACHE : REQ_ICACHE;

  // Grant only when the controller takes the request
  assign d_mgrant = d_sel && fs_ready;
  assign i_mgrant = i_sel && fs_ready;

  // Steer responses by the tag that came back with them
  assign d_mresp_valid = fs_resp_valid && (fs_resp_src == REQ_DCACHE);
  assign i_mresp_valid = fs_resp_valid && (fs_resp_src == REQ_ICACHE);
  assign mresp_data    = fs_resp_data;

  always_ff @(posedge CLK) begin
    if (reset) begin
      i_pend <= 1'b0;
      d_pend <= 1'b0;
    end else begin
      if (i_mgrant)           i_pend <= 1'b1;
      else if (i_mresp_valid) i_pend <= 1'b0;
      if (d_mgrant)           d_pend <= 1'b1;
      else if (d_mresp_valid) d_pend <= 1'b0;
    end
  end

endmodule

`default_nettype wire

/* rtl/memory_controller.sv */
// Module memory_controller, credit-limited issue to external memory with an in-order tag FIFO
`default_nettype none

`include "cache_consts.svh"

module memory_controller
  import cache_pkg::*;
(
  input  wire logic     CLK,
  input  wire logic     reset,
  // Front-side request stream
  input  wire logic     fs_valid,
  input  wire logic     fs_write,
  input  wire addr_t    fs_addr,
  input  wire word_t    fs_wdata,
  input  wire req_src_t fs_src,
  output logic          fs_ready,
  // Responses back to the arbiter, in request order
  output logic          fs_resp_valid,
  output word_t         fs_resp_data,
  output req_src_t      fs_resp_src,
  // External memory link
  output logic          mem_req_valid,
  output logic          mem_req_write,
  output addr_t         mem_req_addr,
  output word_t         mem_req_wdata,
  input  wire logic     mem_credit,
  input  wire logic     mem_resp_valid,
  input  wire word_t    mem_resp_rdata
);

  // Full credit count out of reset, one per memory queue slot
  localparam logic [`MEM_CREDIT_W-1:0] CREDITS_INIT = `MEM_CREDITS;

  logic [`MEM_CREDIT_W-1:0]  credits;
  logic                      issue;

  // Source tag of each issued request, popped by its response
  req_src_t                  tag_fifo [`MEM_CREDITS];
  logic [`MEM_TAG_PTR_W-1:0] wr_ptr;
  logic [`MEM_TAG_PTR_W-1:0] rd_ptr;

  assign fs_ready = (credits != '0);                   // At least one slot free
  assign issue    = fs_valid && fs_ready;

  // Accepted requests leave in the same cycle
  assign mem_req_valid = issue;
  assign mem_req_write = fs_write;
  assign mem_req_addr  = fs_addr;
  assign mem_req_wdata = fs_wdata;

  // Each memory response is labelled with the oldest tag
  assign fs_resp_valid = mem_resp_valid;
  assign fs_resp_data  = mem_resp_rdata;               // Don't care for stores
  assign fs_resp_src   = tag_fifo[rd_ptr];

  // Issue takes a credit, a dequeue in memory gives one back
  always_ff @(posedge CLK) begin
    if (reset) begin
      credits <= CREDITS_INIT;
    end else begin
      case ({issue, mem_credit})
        2'b10:   credits <= credits - 1'b1;
        2'b01:   credits <= credits + 1'b1;
        default: credits <= credits;                   // Both or neither cancel out
      endcase
    end
  end

  // FIFO pointers, depth is a power of two so they wrap by themselves
  always_ff @(posedge CLK) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (issue)          wr_ptr <= wr_ptr + 1'b1;
      if (mem_resp_valid) rd_ptr <= rd_ptr + 1'b1;
    end
  end

  // Tag storage
  // One outstanding access per cache keeps this from overflowing
  always_ff @(posedge CLK) begin
    if (issue) tag_fifo[wr_ptr] <= fs_src;
  end

endmodule

`default_nettype wire

/* rtl/separate_caches.sv */
// Module separate_caches, instruction and data L1s, arbiter and shared flush sequencer
`default_nettype none

`include "cache_consts.svh"

module separate_caches
  import cache_pkg::*;
(
  input  wire logic     CLK,
  input  wire logic     reset,
  // Instruction fetch port
  input  wire logic     icache_ren,
  input  wire logic     icache_wen,
  input  wire addr_t    icache_addr,
  output word_t         icache_rdata,
  output logic          icache_busy,
  // Load/store port
  input  wire logic     dcache_ren,
  input  wire logic     dcache_wen,
  input  wire addr_t    dcache_addr,
  input  wire word_t    dcache_wdata,
  output word_t         dcache_rdata,
  output logic          dcache_busy,
  // Flush handshake and performance pulses
  input  wire logic     flush,
  output logic          flush_done,
  output logic          icache_hit,
  output logic          icache_miss,
  output logic          dcache_hit,
  output logic          dcache_miss,
  // Front-side stream to the memory controller
  output logic          fs_valid,
  output logic          fs_write,
  output addr_t         fs_addr,
  output word_t         fs_wdata,
  output req_src_t      fs_src,
  input  wire logic     fs_ready,
  input  wire logic     fs_resp_valid,
  input  wire word_t    fs_resp_data,
  input  wire req_src_t fs_resp_src
);

  localparam int LAST_LINE = `CACHE_LINES - 1;

  logic                      flush_active;
  logic [`CACHE_INDEX_W-1:0] flush_cnt;     // Line being cleared

  // Cache to arbiter wiring
  logic  i_mreq, i_mgrant, i_mresp_valid;
  addr_t i_maddr;
  logic  d_mreq, d_mwrite, d_mgrant, d_mresp_valid;
  addr_t d_maddr;
  word_t d_mwdata;
  word_t mresp_data;

  // Walk starts the cycle after the flush pulse, one line per cycle
  always_ff @(posedge CLK) begin
    if (reset) begin
      flush_active <= 1'b0;
      flush_cnt    <= '0;
    end else if (flush && !flush_active) begin
      flush_active <= 1'b1;
      flush_cnt    <= '0;
    end else if (flush_active) begin
      flush_cnt <= flush_cnt + 1'b1;
      if (flush_cnt == LAST_LINE[`CACHE_INDEX_W-1:0]) flush_active <= 1'b0;
    end
  end

  // Done together with the last line, CACHE_LINES cycles after the pulse
  assign flush_done = flush_active && (flush_cnt == LAST_LINE[`CACHE_INDEX_W-1:0]);

  l1_cache #(.WRITABLE(0)) icache0 (
    .CLK(CLK), .reset(reset),
    .flush_step(flush_active), .flush_index(flush_cnt),
    .ren(icache_ren), .wen(icache_wen), .addr(icache_addr), .wdata('0),
    .rdata(icache_rdata), .busy(icache_busy), .hit(icache_hit), .miss(icache_miss),
    .mreq(i_mreq), .mwrite(), .maddr(i_maddr), .mwdata(),   // Never writes
    .mgrant(i_mgrant), .mresp_valid(i_mresp_valid), .mresp_data(mresp_data)
  );

  l1_cache #(.WRITABLE(1)) dcache0 (
    .CLK(CLK), .reset(reset),
    .flush_step(flush_active), .flush_index(flush_cnt),
    .ren(dcache_ren), .wen(dcache_wen), .addr(dcache_addr), .wdata(dcache_wdata),
    .rdata(dcache_rdata), .busy(dcache_busy), .hit(dcache_hit), .miss(dcache_miss),
    .mreq(d_mreq), .mwrite(d_mwrite), .maddr(d_maddr), .mwdata(d_mwdata),
    .mgrant(d_mgrant), .mresp_valid(d_mresp_valid), .mresp_data(mresp_data)
  );

  front_side_arbiter arb0 (
    .CLK(CLK), .reset(reset),
    .i_mreq(i_mreq), .i_maddr(i_maddr),
    .i_mgrant(i_mgrant), .i_mresp_valid(i_mresp_valid),
    .d_mreq(d_mreq), .d_mwrite(d_mwrite), .d_maddr(d_maddr), .d_mwdata(d_mwdata),
    .d_mgrant(d_mgrant), .d_mresp_valid(d_mresp_valid),
    .mresp_data(mresp_data),
    .fs_valid(fs_valid), .fs_write(fs_write), .fs_addr(fs_addr),
    .fs_wdata(fs_wdata), .fs_src(fs_src), .fs_ready(fs_ready),
    .fs_resp_valid(fs_resp_valid), .fs_resp_data(fs_resp_data),
    .fs_resp_src(fs_resp_src)
  );

endmodule

`default_nettype wire

/* rtl/supervisor_cache_wrapper.sv */
// Module supervisor_cache_wrapper, top joining the split L1s and the memory controller
`default_nettype none

module supervisor_cache_wrapper
  import cache_pkg::*;
(
  input  wire logic  CLK,
  input  wire logic  reset,
  // Instruction fetch port
  input  wire logic  icache_ren,
  input  wire logic  icache_wen,
  input  wire addr_t icache_addr,
  output word_t      icache_rdata,
  output logic       icache_busy,
  // Load/store port
  input  wire logic  dcache_ren,
  input  wire logic  dcache_wen,
  input  wire addr_t dcache_addr,
  input  wire word_t dcache_wdata,
  output word_t      dcache_rdata,
  output logic       dcache_busy,
  // Flush and performance counting
  input  wire logic  flush,
  output logic       flush_done,
  output logic       icache_hit,
  output logic       icache_miss,
  output logic       dcache_hit,
  output logic       dcache_miss,
  // Credit-based external memory link
  output logic       mem_req_valid,
  output logic       mem_req_write,
  output addr_t      mem_req_addr,
  output word_t      mem_req_wdata,
  input  wire logic  mem_credit,
  input  wire logic  mem_resp_valid,
  input  wire word_t mem_resp_rdata
);

  // Front-side stream between caches and controller
  logic     fs_valid, fs_write, fs_ready, fs_resp_valid;
  addr_t    fs_addr;
  word_t    fs_wdata, fs_resp_data;
  req_src_t fs_src, fs_resp_src;

  separate_caches caches0 (
    .CLK(CLK), .reset(reset),
    .icache_ren(icache_ren), .icache_wen(icache_wen), .icache_addr(icache_addr),
    .icache_rdata(icache_rdata), .icache_busy(icache_busy),
    .dcache_ren(dcache_ren), .dcache_wen(dcache_wen), .dcache_addr(dcache_addr),
    .dcache_wdata(dcache_wdata), .dcache_rdata(dcache_rdata), .dcache_busy(dcache_busy),
    .flush(flush), .flush_done(flush_done),
    .icache_hit(icache_hit), .icache_miss(icache_miss),
    .dcache_hit(dcache_hit), .dcache_miss(dcache_miss),
    .fs_valid(fs_valid), .fs_write(fs_write), .fs_addr(fs_addr),
    .fs_wdata(fs_wdata), .fs_src(fs_src), .fs_ready(fs_ready),
    .fs_resp_valid(fs_resp_valid), .fs_resp_data(fs_resp_data), .fs_resp_src(fs_resp_src)
  );

  memory_controller mc0 (
    .CLK(CLK), .reset(reset),
    .fs_valid(fs_valid), .fs_write(fs_write), .fs_addr(fs_addr),
    .fs_wdata(fs_wdata), .fs_src(fs_src), .fs_ready(fs_ready),
    .fs_resp_valid(fs_resp_valid), .fs_resp_data(fs_resp_data), .fs_resp_src(fs_resp_src),
    .mem_req_valid(mem_req_valid), .mem_req_write(mem_req_write),
    .mem_req_addr(mem_req_addr), .mem_req_wdata(mem_req_wdata),
    .mem_credit(mem_credit), .mem_resp_valid(mem_resp_valid),
    .mem_resp_rdata(mem_resp_rdata)
  );

endmodule

`default_nettype wire

/* sim/mem_model.sv */
// Module mem_model, external memory with a credit-returning request queue and random service delay
`default_nettype none

module mem_model
  import cache_pkg::*;
(
  input  wire logic       CLK,
  input  wire logic       reset,
  // Request side of the credit link
  input  wire logic       mem_req_valid,
  input  wire logic       mem_req_write,
  input  wire addr_t      mem_req_addr,
  input  wire word_t      mem_req_wdata,
  input  wire logic [1:0] delay,           // Service time of the next head entry, minus one
  // Credit return and in-order responses
  output logic            mem_credit,
  output logic            mem_resp_valid,
  output word_t           mem_resp_rdata
);

  word_t store [logic [29:0]];             // Written words only
  logic  q_write [$];                      // Input queue, one entry per held credit
  addr_t q_addr  [$];
  word_t q_wdata [$];
  logic  armed;                            // Head entry has its delay loaded
  int    remain;

  // Unwritten words follow the word address fill pattern
  function automatic word_t read_word(input addr_t a);
    if (store.exists(a[31:2])) return store[a[31:2]];
    return {2'b00, a[31:2]} ^ 32'h5a5a0000;
  endfunction

  initial begin
    mem_credit     = 1'b0;
    mem_resp_valid = 1'b0;
    mem_resp_rdata = '0;
  end

  always @(posedge CLK) begin
    if (reset) begin
      q_write.delete();
      q_addr.delete();
      q_wdata.delete();
      armed          = 1'b0;
      remain         = 0;
      mem_credit     <= 1'b0;
      mem_resp_valid <= 1'b0;
      mem_resp_rdata <= '0;
    end else begin
      mem_credit     <= 1'b0;               // Both are single-cycle pulses
      mem_resp_valid <= 1'b0;
      // Head entry leaves once its delay runs out
      if (q_addr.size() != 0) begin
        if (!armed) begin
          armed  = 1'b1;
          remain = int'(delay) + 1;         // 1 to 4 cycles
        end
        remain = remain - 1;
        if (remain == 0) begin
          armed          = 1'b0;
          mem_credit     <= 1'b1;           // Slot free again
          mem_resp_valid <= 1'b1;
          mem_resp_rdata <= q_write[0] ? '0 : read_word(q_addr[0]);
          if (q_write[0]) store[q_addr[0][31:2]] = q_wdata[0];
          q_write.delete(0);
          q_addr.delete(0);
          q_wdata.delete(0);
        end
      end
      // New request joins after the service step, so it waits at least a cycle
      if (mem_req_valid) begin
        q_write.push_back(mem_req_write);
        q_addr.push_back(mem_req_addr);
        q_wdata.push_back(mem_req_wdata);
      end
    end
  end

endmodule

`default_nettype wire

/* sim/tb_supervisor_cache.sv */
// Testbench tb_supervisor_cache with a stimulus table, memory mirror and response checks
`default_nettype none

`include "cache_consts.svh"

module tb_supervisor_cache
  import cache_pkg::*;
();

  localparam logic [31:0] SEED       = 32'h933679e8;
  localparam int          WAIT_LIMIT = 100;     // Cycles before a wait gives up
  localparam logic [1:0]  OP_READ    = 2'd0;
  localparam logic [1:0]  OP_WRITE   = 2'd1;
  localparam logic [1:0]  OP_FLUSH   = 2'd2;
  localparam logic [1:0]  OP_DUAL    = 2'd3;    // Instruction and data reads together

  typedef struct packed {
    logic [1:0] op;
    logic       port;                           // 0 instruction, 1 data
    addr_t      addr;
    word_t      wdata;                          // Data port address on dual reads
    word_t      exp_data;                       // Instruction side on dual reads
    logic       exp_hit;
  } row_t;

  logic  CLK;
  logic  reset;
  logic  icache_ren, icache_wen, icache_busy, icache_hit, icache_miss;
  addr_t icache_addr;
  word_t icache_rdata;
  logic  dcache_ren, dcache_wen, dcache_busy, dcache_hit, dcache_miss;
  addr_t dcache_addr;
  word_t dcache_wdata, dcache_rdata;
  logic  flush, flush_done;
  logic  mem_req_valid, mem_req_write, mem_credit, mem_resp_valid;
  addr_t mem_req_addr;
  word_t mem_req_wdata, mem_resp_rdata;
  logic [1:0]  mem_delay;
  logic [31:0] rng_state;

  row_t  rows [$];
  word_t mirror [logic [29:0]];                 // Words written by the testbench
  int    outstanding = 0;                       // Requests seen at the mem_ ports and not yet answered

  supervisor_cache_wrapper dut0 (
    .CLK(CLK), .reset(reset),
    .icache_ren(icache_ren), .icache_wen(icache_wen), .icache_addr(icache_addr),
    .icache_rdata(icache_rdata), .icache_busy(icache_busy),
    .dcache_ren(dcache_ren), .dcache_wen(dcache_wen), .dcache_addr(dcache_addr),
    .dcache_wdata(dcache_wdata), .dcache_rdata(dcache_rdata), .dcache_busy(dcache_busy),
    .flush(flush), .flush_done(flush_done),
    .icache_hit(icache_hit), .icache_miss(icache_miss),
    .dcache_hit(dcache_hit), .dcache_miss(dcache_miss),
    .mem_req_valid(mem_req_valid), .mem_req_write(mem_req_write),
    .mem_req_addr(mem_req_addr), .mem_req_wdata(mem_req_wdata),
    .mem_credit(mem_credit), .mem_resp_valid(mem_resp_valid),
    .mem_resp_rdata(mem_resp_rdata)
  );

  mem_model mem0 (
    .CLK(CLK), .reset(reset),
    .mem_req_valid(mem_req_valid), .mem_req_write(mem_req_write),
    .mem_req_addr(mem_req_addr), .mem_req_wdata(mem_req_wdata), .delay(mem_delay),
    .mem_credit(mem_credit), .mem_resp_valid(mem_resp_valid),
    .mem_resp_rdata(mem_resp_rdata)
  );

  initial begin
    CLK = 1'b0;
    forever #5 CLK = ~CLK;
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  // Memory content as the mirror sees it
  function automatic word_t expected_word(input addr_t a);
    if (mirror.exists(a[31:2])) return mirror[a[31:2]];
    return {2'b00, a[31:2]} ^ 32'h5a5a0000;
  endfunction

  // New service delay every cycle from the top bits of the LCG
  always @(posedge CLK) begin
    rng_state <= lcg_next(rng_state);
    mem_delay <= rng_state[31:30];
  end

  // In-flight count on the external link
  always @(negedge CLK) begin
    if (reset) begin
      outstanding = 0;
    end else begin
      outstanding = outstanding + int'(mem_req_valid) - int'(mem_resp_valid);
      assert (outstanding <= `MEM_CREDITS)
        else report_mismatch("outstanding memory requests", outstanding, `MEM_CREDITS);
    end
  end

  task automatic stop_run();
    $display("Test failed");
    $fatal(1, "Stopping at the first error");
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] expected);
    $display("Fail %s: got %h, expected %h", name, got, expected);
    stop_run();
  endtask

  task automatic report_problem(input string what);
    $display("%s", what);
    stop_run();
  endtask

  task automatic check_low(input string name, input logic value);
    assert (value == 1'b0) else report_mismatch(name, {31'd0, value}, 32'd0);
  endtask

  task automatic add_row(input logic [1:0] op, input logic port, input addr_t a,
                         input word_t wdata, input word_t exp_data, input logic exp_hit);
    row_t r;
    r.op       = op;
    r.port     = port;
    r.addr     = a;
    r.wdata    = wdata;
    r.exp_data = exp_data;
    r.exp_hit  = exp_hit;
    rows.push_back(r);
  endtask

  task automatic load_table();
    add_row(OP_READ,  1'b0, 32'h100, '0, 32'h5a5a0040, 1'b0);          // Cold miss
    add_row(OP_READ,  1'b0, 32'h100, '0, 32'h5a5a0040, 1'b1);
    add_row(OP_READ,  1'b1, 32'h204, '0, 32'h5a5a0081, 1'b0);
    add_row(OP_READ,  1'b1, 32'h204, '0, 32'h5a5a0081, 1'b1);
    add_row(OP_READ,  1'b0, 32'h308, '0, 32'h5a5a00c2, 1'b0);
    add_row(OP_WRITE, 1'b1, 32'h204, 32'hcafe0001, '0, 1'b0);          // Store hit
    add_row(OP_READ,  1'b1, 32'h204, '0, 32'hcafe0001, 1'b1);
    add_row(OP_WRITE, 1'b1, 32'h308, 32'hbeef0002, '0, 1'b0);          // Store miss without allocate
    add_row(OP_READ,  1'b1, 32'h308, '0, 32'hbeef0002, 1'b0);
    add_row(OP_READ,  1'b0, 32'h308, '0, 32'h5a5a00c2, 1'b1);          // Stale instruction line
    add_row(OP_WRITE, 1'b1, 32'h410, 32'h12345678, '0, 1'b0);
    add_row(OP_READ,  1'b0, 32'h410, '0, 32'h12345678, 1'b0);
    add_row(OP_DUAL,  1'b0, 32'h514, 32'h61c, 32'h5a5a0145, 1'b0);
    add_row(OP_FLUSH, 1'b0, '0, '0, '0, 1'b0);
    add_row(OP_READ,  1'b0, 32'h100, '0, 32'h5a5a0040, 1'b0);
    add_row(OP_READ,  1'b1, 32'h204, '0, 32'hcafe0001, 1'b0);
    add_row(OP_READ,  1'b0, 32'h308, '0, 32'hbeef0002, 1'b0);          // Stale line refetched
    add_row(OP_READ,  1'b1, 32'h308, '0, 32'hbeef0002, 1'b0);
    add_row(OP_DUAL,  1'b0, 32'h808, 32'h918, 32'h5a5a0202, 1'b0);
    add_row(OP_READ,  1'b1, 32'h918, '0, 32'h5a5a0246, 1'b1);
  endtask

  // One or two reads with each port released on its own completing edge
  task automatic run_reads(input logic do_i, input addr_t i_addr, input logic do_d,
                           input addr_t d_addr, input word_t i_exp, input word_t d_exp,
                           input logic exp_hit);
    logic i_done;
    logic d_done;
    int   cycles;
    i_done = !do_i;
    d_done = !do_d;
    cycles = 0;
    @(posedge CLK);
    if (do_i) begin
      icache_ren  <= 1'b1;
      icache_addr <= i_addr;
    end
    if (do_d) begin
      dcache_ren  <= 1'b1;
      dcache_addr <= d_addr;
    end
    @(negedge CLK);
    // Lookup outcome shows in the request cycle
    if (do_i) begin
      assert (icache_hit == exp_hit) else report_mismatch("icache_hit", icache_hit, exp_hit);
      assert (icache_miss == !exp_hit) else report_mismatch("icache_miss", icache_miss, !exp_hit);
      if (exp_hit) check_low("icache_busy", icache_busy);
    end
    if (do_d) begin
      assert (dcache_hit == exp_hit) else report_mismatch("dcache_hit", dcache_hit, exp_hit);
      assert (dcache_miss == !exp_hit) else report_mismatch("dcache_miss", dcache_miss, !exp_hit);
      if (exp_hit) check_low("dcache_busy", dcache_busy);
    end
    while (!(i_done && d_done)) begin
      if (!i_done && !icache_busy) begin
        i_done = 1'b1;
        assert (icache_rdata == i_exp) else report_mismatch("icache_rdata", icache_rdata, i_exp);
      end
      if (!d_done && !dcache_busy) begin
        d_done = 1'b1;
        assert (dcache_rdata == d_exp) else report_mismatch("dcache_rdata", dcache_rdata, d_exp);
      end
      @(posedge CLK);
      if (i_done) icache_ren <= 1'b0;
      if (d_done) dcache_ren <= 1'b0;
      if (!(i_done && d_done)) begin
        cycles++;
        if (cycles > WAIT_LIMIT) report_problem("Timed out waiting for a read to complete");
        @(negedge CLK);
      end
    end
  endtask

  task automatic run_write(input addr_t a, input word_t d);
    int cycles;
    cycles = 0;
    @(posedge CLK);
    dcache_wen   <= 1'b1;
    dcache_addr  <= a;
    dcache_wdata <= d;
    @(negedge CLK);
    while (dcache_busy) begin
      cycles++;
      if (cycles > WAIT_LIMIT) report_problem("Timed out waiting for a write to complete");
      @(negedge CLK);
    end
    @(posedge CLK);
    dcache_wen <= 1'b0;
    mirror[a[31:2]] = d;                          // Write-through reached memory
  endtask

  task automatic run_flush();
    int cycles;
    cycles = 0;
    @(posedge CLK);
    flush <= 1'b1;
    @(negedge CLK);
    while (!flush_done) begin
      cycles++;
      if (cycles > WAIT_LIMIT) report_problem("Timed out waiting for flush_done");
      @(posedge CLK);
      flush <= 1'b0;                              // Single-cycle pulse
      @(negedge CLK);
    end
    assert (cycles == `CACHE_LINES)
      else report_mismatch("flush_done delay", cycles, `CACHE_LINES);
    @(posedge CLK);
    flush <= 1'b0;
    @(negedge CLK);
    check_low("flush_done", flush_done);
  endtask

  task automatic apply_row(input row_t r);
    // Any miss has to bring back what memory holds
    if (r.op != OP_WRITE && r.op != OP_FLUSH && !r.exp_hit) begin
      assert (r.exp_data == expected_word(r.addr))
        else report_problem("Table entry disagrees with the memory mirror");
    end
    case (r.op)
      OP_READ: begin
        if (r.port) run_reads(1'b0, '0, 1'b1, r.addr, '0, r.exp_data, r.exp_hit);
        else run_reads(1'b1, r.addr, 1'b0, '0, r.exp_data, '0, r.exp_hit);
      end
      OP_WRITE: run_write(r.addr, r.wdata);
      OP_FLUSH: run_flush();
      default: run_reads(1'b1, r.addr, 1'b1, r.wdata, r.exp_data, expected_word(r.wdata),
                         r.exp_hit);
    endcase
  endtask

  initial begin
    reset        = 1'b1;
    icache_ren   = 1'b0;
    icache_wen   = 1'b0;
    icache_addr  = '0;
    dcache_ren   = 1'b0;
    dcache_wen   = 1'b0;
    dcache_addr  = '0;
    dcache_wdata = '0;
    flush        = 1'b0;
    rng_state    = SEED;
    mem_delay    = 2'd0;
    load_table();
    repeat (8) @(posedge CLK);
    reset <= 1'b0;
    // Everything quiet for a few cycles after reset
    repeat (4) begin
      @(negedge CLK);
      check_low("icache_busy", icache_busy);
      check_low("dcache_busy", dcache_busy);
      check_low("flush_done", flush_done);
      check_low("icache_hit", icache_hit);
      check_low("icache_miss", icache_miss);
      check_low("dcache_hit", dcache_hit);
      check_low("dcache_miss", dcache_miss);
      check_low("mem_req_valid", mem_req_valid);
    end
    foreach (rows[i]) apply_row(rows[i]);
    $display("Test passed");
    $finish;
  end

endmodule

`default_nettype wire

/* supervisor_cache_wrapper.f */
+incdir+rtl
rtl/cache_pkg.sv
rtl/l1_cache.sv
rtl/front_side_arbiter.sv
rtl/memory_controller.sv
rtl/separate_caches.sv
rtl/supervisor_cache_wrapper.sv
sim/mem_model.sv
sim/tb_supervisor_cache.sv
